// File: common/cpu_pkg.sv
package cpu_pkg;

  // datapath widths
  localparam int data_w = 32;
  localparam int addr_w = 16;
  localparam int imm_w = 16;
  localparam int op_w = 4;

  // register context layout
  localparam int num_regs = 16;
  localparam int idx_w = $clog2(num_regs);
  // last word of a context holds the instruction pointer
  localparam logic [idx_w-1:0] reg_ip = idx_w'(num_regs - 1);

  // sequencer phases, one unit active per phase
  localparam logic [2:0] ph_idle = 3'd0;
  localparam logic [2:0] ph_fetch = 3'd1;
  localparam logic [2:0] ph_decode = 3'd2;
  localparam logic [2:0] ph_exec = 3'd3;
  localparam logic [2:0] ph_write = 3'd4;
  localparam logic [2:0] ph_next_ip = 3'd5;

  // opcodes, register form
  localparam logic [op_w-1:0] op_add = 4'h1;
  localparam logic [op_w-1:0] op_sub = 4'h2;
  localparam logic [op_w-1:0] op_and = 4'h3;
  localparam logic [op_w-1:0] op_or = 4'h4;
  localparam logic [op_w-1:0] op_xor = 4'h5;
  // opcodes, immediate form
  localparam logic [op_w-1:0] op_ldi = 4'h6;
  localparam logic [op_w-1:0] op_jnz = 4'h7;
  // stops the core, pointer left on this word
  localparam logic [op_w-1:0] op_halt = 4'hf;

  // one command word, two decodings
  // opcode and dst sit in the same bits in both views
  typedef union packed {
    struct packed {
      logic [op_w-1:0] opcode;
      logic [idx_w-1:0] dst;
      logic [idx_w-1:0] src0;
      logic [idx_w-1:0] src1;
      logic [15:0] unused;
    } regv;
    struct packed {
      logic [op_w-1:0] opcode;
      logic [idx_w-1:0] dst;
      logic [3:0] pad;
      logic [imm_w-1:0] imm;
      // low nibble left spare in this view
      logic [3:0] spare;
    } immv;
  } cmd_word_t;

  // ldi and jnz carry an immediate instead of two source indices
  function automatic logic is_imm_op(input logic [op_w-1:0] opcode);
    return (opcode == op_ldi) || (opcode == op_jnz);
  endfunction

endpackage

// File: common/cpu_ifs.sv
`timescale 1ns/1ps

// word-addressed memory port with one-cycle strobes
interface mem_bus_if import cpu_pkg::*; ();
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic [data_w-1:0] rdata;
  // request strobes, one cycle each
  logic read_q;
  logic write_q;
  // answers from memory, one cycle each
  logic read_dn;
  logic write_dn;

  modport master (
    output addr,
    output wdata,
    output read_q,
    output write_q,
    input rdata,
    input read_dn,
    input write_dn
  );

  modport slave (
    input addr,
    input wdata,
    input read_q,
    input write_q,
    output rdata,
    output read_dn,
    output write_dn
  );
endinterface

// decoded command with both operand values fetched
interface op_if import cpu_pkg::*; ();
  logic [op_w-1:0] op;
  logic [idx_w-1:0] dst_idx;
  logic [data_w-1:0] src0_val;
  logic [data_w-1:0] src1_val;
  logic [imm_w-1:0] imm;

  modport src (output op, output dst_idx, output src0_val, output src1_val, output imm);
  modport dst (input op, input dst_idx, input src0_val, input src1_val, input imm);
endinterface

// execute outcome, used by the writer and by the pointer update
interface result_if import cpu_pkg::*; ();
  logic [data_w-1:0] result;
  logic [idx_w-1:0] dst_idx;
  logic wr_en;
  logic taken;
  logic [addr_w-1:0] target;

  modport src (output result, output dst_idx, output wr_en, output taken, output target);
  modport dst (input result, input dst_idx, input wr_en, input taken, input target);
endinterface

// File: source/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; (
  input logic clk,
  input logic rst,
  input logic start,
  output logic busy,
  input logic is_halt,
  output logic fetch_go,
  output logic dec_go,
  output logic exec_go,
  output logic wr_go,
  output logic ip_go,
  input logic fetch_done,
  input logic dec_done,
  input logic exec_done,
  input logic wr_done,
  input logic ip_done,
  mem_bus_if.slave fetch_bus,
  mem_bus_if.slave dec_bus,
  mem_bus_if.slave wr_bus,
  mem_bus_if.master mem
);

  logic [2:0] phase;
  logic sel_fetch;
  logic sel_dec;
  logic sel_wr;
  // a request is out and its done pulse has not come back yet
  logic pending;

  assign busy = (phase != ph_idle);

  // go pulses are registered along with the phase change
  always_ff @(posedge clk) begin
    fetch_go <= 1'b0;
    dec_go <= 1'b0;
    exec_go <= 1'b0;
    wr_go <= 1'b0;
    ip_go <= 1'b0;
    if (rst) begin
      phase <= ph_idle;
    end else begin
      case (phase)
        ph_idle: if (start) begin
          phase <= ph_fetch;
          fetch_go <= 1'b1;
        end
        ph_fetch: if (fetch_done) begin
          phase <= ph_decode;
          dec_go <= 1'b1;
        end
        ph_decode: if (dec_done) begin
          phase <= ph_exec;
          exec_go <= 1'b1;
        end
        ph_exec: if (exec_done) begin
          // halt drops straight back, no write and no pointer update
          if (is_halt) begin
            phase <= ph_idle;
          end else begin
            phase <= ph_write;
            wr_go <= 1'b1;
          end
        end
        ph_write: if (wr_done) begin
          phase <= ph_next_ip;
          ip_go <= 1'b1;
        end
        ph_next_ip: if (ip_done) begin
          phase <= ph_fetch;
          fetch_go <= 1'b1;
        end
        default: phase <= ph_idle;
      endcase
    end
  end

  // fetch unit owns the bus in both fetch and pointer phases
  assign sel_fetch = (phase == ph_fetch) || (phase == ph_next_ip);
  assign sel_dec = (phase == ph_decode);
  assign sel_wr = (phase == ph_write);

  always_comb begin
    mem.addr = '0;
    mem.wdata = '0;
    mem.read_q = 1'b0;
    mem.write_q = 1'b0;
    if (sel_fetch) begin
      mem.addr = fetch_bus.addr;
      mem.wdata = fetch_bus.wdata;
      mem.read_q = fetch_bus.read_q;
      mem.write_q = fetch_bus.write_q;
    end else if (sel_dec) begin
      mem.addr = dec_bus.addr;
      mem.wdata = dec_bus.wdata;
      mem.read_q = dec_bus.read_q;
      mem.write_q = dec_bus.write_q;
    end else if (sel_wr) begin
      mem.addr = wr_bus.addr;
      mem.wdata = wr_bus.wdata;
      mem.read_q = wr_bus.read_q;
      mem.write_q = wr_bus.write_q;
    end
  end

  // read data fans out, done pulses only reach the active unit
  assign fetch_bus.rdata = mem.rdata;
  assign dec_bus.rdata = mem.rdata;
  assign wr_bus.rdata = mem.rdata;
  assign fetch_bus.read_dn = sel_fetch && mem.read_dn;
  assign fetch_bus.write_dn = sel_fetch && mem.write_dn;
  assign dec_bus.read_dn = sel_dec && mem.read_dn;
  assign dec_bus.write_dn = sel_dec && mem.write_dn;
  assign wr_bus.read_dn = sel_wr && mem.read_dn;
  assign wr_bus.write_dn = sel_wr && mem.write_dn;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (mem.read_q || mem.write_q) begin
      pending <= 1'b1;
    end else if (mem.read_dn || mem.write_dn) begin
      pending <= 1'b0;
    end
  end

  a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
    !(mem.read_q && mem.write_q))
    else $error("read and write requested together");

  a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    (mem.read_q || mem.write_q) |-> !pending)
    else $error("new request before done pulse");

endmodule

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
  input logic clk,
  input logic rst,
  input logic start,
  input logic [addr_w-1:0] start_base,
  input logic go,
  input logic ip_go,
  output logic done,
  output logic ip_done,
  output logic [addr_w-1:0] base_addr,
  output cmd_word_t cmd,
  mem_bus_if.master bus,
  result_if.dst res
);

  // instruction pointer as read from the context
  logic [addr_w-1:0] ip;
  logic [addr_w-1:0] next_ip;
  logic [addr_w-1:0] ip_addr;
  // one flag per outstanding access
  logic wait_ip;
  logic wait_cmd;
  logic wait_wr;

  // taken branch jumps, anything else steps one word
  assign next_ip = res.taken ? res.target : ip + addr_w'(1);
  assign ip_addr = base_addr + addr_w'(reg_ip);

  // context base, only loaded by an accepted start
  always_ff @(posedge clk) begin
    if (start) begin
      base_addr <= start_base;
    end
  end

  always_ff @(posedge clk) begin
    bus.read_q <= 1'b0;
    bus.write_q <= 1'b0;
    done <= 1'b0;
    ip_done <= 1'b0;
    if (rst) begin
      wait_ip <= 1'b0;
      wait_cmd <= 1'b0;
      wait_wr <= 1'b0;
    end else begin
      // first read of a fetch, the pointer register
      if (go) begin
        bus.addr <= ip_addr;
        bus.read_q <= 1'b1;
        wait_ip <= 1'b1;
      end else if (ip_go) begin
        bus.addr <= ip_addr;
        bus.wdata <= data_w'(next_ip);
        bus.write_q <= 1'b1;
        wait_wr <= 1'b1;
      end
      // pointer back, follow it to the command word
      if (wait_ip && bus.read_dn) begin
        ip <= bus.rdata[addr_w-1:0];
        bus.addr <= bus.rdata[addr_w-1:0];
        bus.read_q <= 1'b1;
        wait_ip <= 1'b0;
        wait_cmd <= 1'b1;
      end
      if (wait_cmd && bus.read_dn) begin
        cmd <= bus.rdata;
        done <= 1'b1;
        wait_cmd <= 1'b0;
      end
      if (wait_wr && bus.write_dn) begin
        ip_done <= 1'b1;
        wait_wr <= 1'b0;
      end
    end
  end

  // command word arrives from the address the held pointer names
  a_cmd_at_ip: assert property (@(posedge clk) disable iff (rst)
    (wait_cmd && bus.read_dn) |-> (bus.addr == ip))
    else $error("command read address differs from fetched pointer");

endmodule

// File: decode/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder import cpu_pkg::*; (
  input logic clk,
  input logic rst,
  input logic go,
  output logic done,
  input logic [addr_w-1:0] base_addr,
  input cmd_word_t cmd,
  output logic is_halt,
  mem_bus_if.master bus,
  op_if.src op
);

  logic imm_form;
  logic [idx_w-1:0] idx0;
  logic [idx_w-1:0] idx1;
  // second operand index, held while the first read is out
  logic [idx_w-1:0] idx1_q;
  logic wait0;
  logic wait1;

  // view chosen by opcode, opcode bits are common to both
  assign imm_form = is_imm_op(cmd.regv.opcode);
  // immediate form reads the dst register into both operands
  assign idx0 = imm_form ? cmd.immv.dst : cmd.regv.src0;
  assign idx1 = imm_form ? cmd.immv.dst : cmd.regv.src1;

  // sampled by the sequencer when execute finishes
  assign is_halt = (op.op == op_halt);

  always_ff @(posedge clk) begin
    bus.read_q <= 1'b0;
    done <= 1'b0;
    if (rst) begin
      wait0 <= 1'b0;
      wait1 <= 1'b0;
    end else begin
      if (go) begin
        op.op <= cmd.regv.opcode;
        op.dst_idx <= cmd.regv.dst;
        op.imm <= imm_form ? cmd.immv.imm : '0;
        idx1_q <= idx1;
        bus.addr <= base_addr + addr_w'(idx0);
        bus.read_q <= 1'b1;
        wait0 <= 1'b1;
      end
      // first operand in, ask for the second
      if (wait0 && bus.read_dn) begin
        op.src0_val <= bus.rdata;
        bus.addr <= base_addr + addr_w'(idx1_q);
        bus.read_q <= 1'b1;
        wait0 <= 1'b0;
        wait1 <= 1'b1;
      end
      if (wait1 && bus.read_dn) begin
        op.src1_val <= bus.rdata;
        done <= 1'b1;
        wait1 <= 1'b0;
      end
    end
  end

  // decoder only reads, write side parked
  assign bus.write_q = 1'b0;
  assign bus.wdata = '0;

endmodule

// File: execute/alu_execute.sv
`timescale 1ns/1ps

module alu_execute import cpu_pkg::*; (
  input logic clk,
  input logic rst,
  input logic go,
  output logic done,
  op_if.dst op,
  result_if.src res
);

  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
      res.wr_en <= 1'b0;
      res.taken <= 1'b0;
    end else begin
      // single-cycle execute
      done <= go;
      if (go) begin
        res.dst_idx <= op.dst_idx;
        res.target <= addr_w'(op.imm);
        res.result <= '0;
        res.wr_en <= 1'b0;
        res.taken <= 1'b0;
        case (op.op)
          op_add: begin
            res.result <= op.src0_val + op.src1_val;
            res.wr_en <= 1'b1;
          end
          op_sub: begin
            res.result <= op.src0_val - op.src1_val;
            res.wr_en <= 1'b1;
          end
          op_and: begin
            res.result <= op.src0_val & op.src1_val;
            res.wr_en <= 1'b1;
          end
          op_or: begin
            res.result <= op.src0_val | op.src1_val;
            res.wr_en <= 1'b1;
          end
          op_xor: begin
            res.result <= op.src0_val ^ op.src1_val;
            res.wr_en <= 1'b1;
          end
          op_ldi: begin
            res.result <= data_w'(op.imm);
            res.wr_en <= 1'b1;
          end
          // src0 holds the condition register here
          op_jnz: res.taken <= (op.src0_val != '0);
          // halt and unknown codes leave registers alone
          default: ;
        endcase
      end
    end
  end

  // sequencer must not retrigger while the result is being reported
  a_done_after_go: assert property (@(posedge clk) disable iff (rst)
    go |=> (done && !go))
    else $error("execute done missing or go repeated");

endmodule

// File: source/result_writer.sv
`timescale 1ns/1ps

module result_writer import cpu_pkg::*; (
  input logic clk,
  input logic rst,
  input logic go,
  output logic done,
  input logic [addr_w-1:0] base_addr,
  result_if.dst res,
  mem_bus_if.master bus
);

  logic wait_wr;

  always_ff @(posedge clk) begin
    bus.write_q <= 1'b0;
    done <= 1'b0;
    if (rst) begin
      wait_wr <= 1'b0;
    end else begin
      if (go) begin
        if (res.wr_en) begin
          bus.addr <= base_addr + addr_w'(res.dst_idx);
          bus.wdata <= res.result;
          bus.write_q <= 1'b1;
          wait_wr <= 1'b1;
        end else begin
          // nothing to store, finish right away
          done <= 1'b1;
        end
      end
      if (wait_wr && bus.write_dn) begin
        done <= 1'b1;
        wait_wr <= 1'b0;
      end
    end
  end

  // write-only master
  assign bus.read_q = 1'b0;

endmodule

// File: source/mem_cpu_top.sv
`timescale 1ns/1ps

module mem_cpu_top import cpu_pkg::*; (
  input logic clk,
  input logic rst,
  input logic start,
  input logic [addr_w-1:0] start_base,
  output logic busy,
  output logic [addr_w-1:0] mem_addr,
  output logic [data_w-1:0] mem_wdata,
  input logic [data_w-1:0] mem_rdata,
  output logic mem_read_q,
  output logic mem_write_q,
  input logic mem_read_dn,
  input logic mem_write_dn
);

  // one bus per master plus the shared external one
  mem_bus_if fetch_bus ();
  mem_bus_if dec_bus ();
  mem_bus_if wr_bus ();
  mem_bus_if mem_bus ();
  op_if op_bus ();
  result_if res_bus ();

  logic start_ok;
  logic [addr_w-1:0] base_addr;
  cmd_word_t cmd;
  logic is_halt;
  logic fetch_go;
  logic dec_go;
  logic exec_go;
  logic wr_go;
  logic ip_go;
  logic fetch_done;
  logic dec_done;
  logic exec_done;
  logic wr_done;
  logic ip_done;

  // start while running is dropped, base stays put
  assign start_ok = start && !busy;

  cpu_sequencer u_seq (
    .clk(clk), .rst(rst), .start(start_ok), .busy(busy), .is_halt(is_halt),
    .fetch_go(fetch_go), .dec_go(dec_go), .exec_go(exec_go), .wr_go(wr_go), .ip_go(ip_go),
    .fetch_done(fetch_done), .dec_done(dec_done), .exec_done(exec_done),
    .wr_done(wr_done), .ip_done(ip_done),
    .fetch_bus(fetch_bus.slave), .dec_bus(dec_bus.slave), .wr_bus(wr_bus.slave),
    .mem(mem_bus.master)
  );

  fetch_unit u_fetch (
    .clk(clk), .rst(rst), .start(start_ok), .start_base(start_base),
    .go(fetch_go), .ip_go(ip_go), .done(fetch_done), .ip_done(ip_done),
    .base_addr(base_addr), .cmd(cmd), .bus(fetch_bus.master), .res(res_bus.dst)
  );

  cmd_decoder u_dec (
    .clk(clk), .rst(rst), .go(dec_go), .done(dec_done), .base_addr(base_addr),
    .cmd(cmd), .is_halt(is_halt), .bus(dec_bus.master), .op(op_bus.src)
  );

  alu_execute u_alu (
    .clk(clk), .rst(rst), .go(exec_go), .done(exec_done),
    .op(op_bus.dst), .res(res_bus.src)
  );

  result_writer u_wr (
    .clk(clk), .rst(rst), .go(wr_go), .done(wr_done), .base_addr(base_addr),
    .res(res_bus.dst), .bus(wr_bus.master)
  );

  // external memory port
  assign mem_addr = mem_bus.addr;
  assign mem_wdata = mem_bus.wdata;
  assign mem_read_q = mem_bus.read_q;
  assign mem_write_q = mem_bus.write_q;
  assign mem_bus.rdata = mem_rdata;
  assign mem_bus.read_dn = mem_read_dn;
  assign mem_bus.write_dn = mem_write_dn;

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

// free-running clock plus a synchronous reset pulse
module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held over the first 4 rising edges
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: sim/tb_mem_cpu.sv
`timescale 1ns/1ps

module tb_mem_cpu import cpu_pkg::*; ();

  localparam int mem_words = 4096;
  localparam int wait_limit = 20000;
  localparam logic [15:0] base_a = 16'h0100;
  localparam logic [15:0] base_b = 16'h0200;
  localparam logic [15:0] prog_a = 16'h0400;
  localparam logic [15:0] prog_b = 16'h0600;

  logic clk;
  logic rst;
  logic start;
  logic [addr_w-1:0] start_base;
  logic busy;
  logic [addr_w-1:0] mem_addr;
  logic [data_w-1:0] mem_wdata;
  logic [data_w-1:0] mem_rdata = '0;
  logic mem_read_q;
  logic mem_write_q;
  logic mem_read_dn = 1'b0;
  logic mem_write_dn = 1'b0;

  // model storage and the reference copy
  logic [data_w-1:0] mem [mem_words];
  logic [data_w-1:0] ref_mem [mem_words];
  // one outstanding request in the model
  logic pend = 1'b0;
  logic req_read = 1'b0;
  logic [11:0] req_addr = '0;
  int unsigned delay_left = 0;
  // preload path into the model
  logic fill_en;
  logic load_en;
  logic [11:0] load_addr;
  logic [data_w-1:0] load_data;
  logic started;

  tb_clock_gen clkgen (.clk(clk), .rst(rst));

  mem_cpu_top DUT (
    .clk(clk), .rst(rst), .start(start), .start_base(start_base), .busy(busy),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .mem_read_q(mem_read_q), .mem_write_q(mem_write_q),
    .mem_read_dn(mem_read_dn), .mem_write_dn(mem_write_dn)
  );

  function automatic logic [11:0] word_index(input int a);
    return 12'(a);
  endfunction

  // background pattern, every address bit matters
  function automatic logic [data_w-1:0] fill_word(input int a);
    return (32'(a) * 32'h0100_0193) ^ 32'h811c_9dc5;
  endfunction

  function automatic logic [31:0] reg_cmd(input logic [3:0] opc, input logic [3:0] d,
                                          input logic [3:0] s0, input logic [3:0] s1);
    return {opc, d, s0, s1, 16'h0000};
  endfunction

  // immediate sits in bits 19:4
  function automatic logic [31:0] imm_cmd(input logic [3:0] opc, input logic [3:0] d,
                                          input logic [15:0] imm);
    return {opc, d, 4'h0, imm, 4'h0};
  endfunction

  // interprets one context on ref_mem, returns commands executed
  function automatic int run_reference(input logic [15:0] base);
    int steps;
    logic [15:0] ip;
    logic [15:0] nxt;
    logic [31:0] cmd;
    logic [3:0] opc;
    logic [11:0] dst_w;
    logic [31:0] a;
    logic [31:0] b;
    steps = 0;
    while (steps < 1000) begin
      ip = ref_mem[word_index(int'(base) + int'(reg_ip))][15:0];
      cmd = ref_mem[word_index(int'(ip))];
      opc = cmd[31:28];
      dst_w = word_index(int'(base) + int'(cmd[27:24]));
      a = ref_mem[word_index(int'(base) + int'(cmd[23:20]))];
      b = ref_mem[word_index(int'(base) + int'(cmd[19:16]))];
      steps++;
      // halt leaves the pointer on the halt word
      if (opc == op_halt) begin
        return steps;
      end
      nxt = ip + 16'd1;
      case (opc)
        op_add: ref_mem[dst_w] = a + b;
        op_sub: ref_mem[dst_w] = a - b;
        op_and: ref_mem[dst_w] = a & b;
        op_or: ref_mem[dst_w] = a | b;
        op_xor: ref_mem[dst_w] = a ^ b;
        op_ldi: ref_mem[dst_w] = {16'h0000, cmd[19:4]};
        // condition comes from the dst field register
        op_jnz: if (ref_mem[dst_w] != '0) nxt = cmd[19:4];
        default: ;
      endcase
      ref_mem[word_index(int'(base) + int'(reg_ip))] = {16'h0000, nxt};
    end
    return steps;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual));
    end
  endtask

  // one word per cycle through the model's load path
  task automatic put_word(input int addr, input logic [31:0] data);
    ref_mem[word_index(addr)] = data;
    @(posedge clk);
    load_en <= 1'b1;
    load_addr <= word_index(addr);
    load_data <= data;
  endtask

  task automatic end_load;
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic fill_memory;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[word_index(i)] = fill_word(i);
    end
    @(posedge clk);
    fill_en <= 1'b1;
    @(posedge clk);
    fill_en <= 1'b0;
  endtask

  // random registers 0..14, pointer aimed at the program
  task automatic init_context(input logic [15:0] base, input logic [15:0] prog);
    for (int r = 0; r < 15; r++) begin
      put_word(int'(base) + r, $urandom);
    end
    put_word(int'(base) + int'(reg_ip), {16'h0000, prog});
  endtask

  task automatic load_random_program(input logic [15:0] prog, input int len);
    for (int k = 0; k < len; k++) begin
      put_word(int'(prog) + k, reg_cmd(op_add + 4'($urandom % 5), 4'($urandom % 15),
                                       4'($urandom % 15), 4'($urandom % 15)));
    end
    put_word(int'(prog) + len, reg_cmd(op_halt, 4'd0, 4'd0, 4'd0));
  endtask

  task automatic check_context(input string name, input logic [15:0] base);
    for (int r = 0; r < num_regs; r++) begin
      check_value($sformatf("%s r%0d", name, r), ref_mem[word_index(int'(base) + r)],
                  mem[word_index(int'(base) + r)]);
    end
  endtask

  task automatic wait_busy(input logic level, input string name);
    int cycles;
    cycles = 0;
    while (busy !== level) begin
      if (cycles >= wait_limit) begin
        stop_run($sformatf("timeout in %s, busy never went to %0b", name, level));
      end
      @(posedge clk);
      cycles++;
    end
  endtask

  task automatic start_run(input logic [15:0] base);
    @(posedge clk);
    start <= 1'b1;
    start_base <= base;
    started <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic run_and_check(input string name, input logic [15:0] base);
    void'(run_reference(base));
    start_run(base);
    wait_busy(1'b1, name);
    wait_busy(1'b0, name);
    check_context(name, base);
  endtask

  // memory model, answers after 1 to 4 cycles
  always @(posedge clk) begin
    mem_read_dn <= 1'b0;
    mem_write_dn <= 1'b0;
    if (fill_en) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[word_index(i)] <= fill_word(i);
      end
    end
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
    if (rst) begin
      pend <= 1'b0;
    end else if (pend) begin
      if (delay_left <= 1) begin
        pend <= 1'b0;
        if (req_read) begin
          mem_read_dn <= 1'b1;
          mem_rdata <= mem[req_addr];
        end else begin
          mem_write_dn <= 1'b1;
        end
      end else begin
        delay_left <= delay_left - 1;
      end
    end else if (mem_read_q || mem_write_q) begin
      pend <= 1'b1;
      req_read <= mem_read_q;
      req_addr <= mem_addr[11:0];
      delay_left <= 1 + ($urandom % 4);
      // write lands at request time
      if (mem_write_q) begin
        mem[mem_addr[11:0]] <= mem_wdata;
      end
    end
  end

  // bus protocol monitor
  always @(posedge clk) begin
    if (!rst) begin
      if (mem_read_q && mem_write_q) begin
        stop_run("read and write requested in the same cycle");
      end
      if ((mem_read_q || mem_write_q) && pend) begin
        stop_run("new memory request while one was still outstanding");
      end
      if ((mem_read_q || mem_write_q) && !started) begin
        stop_run("memory request seen before any start");
      end
    end
  end

  initial begin
    logic [15:0] ldi_imm [8];
    int count;
    int cycles;
    void'($urandom(32'hac1be093));
    start = 1'b0;
    start_base = '0;
    started = 1'b0;
    fill_en = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;

    cycles = 0;
    while (rst !== 1'b0) begin
      if (cycles >= 100) begin
        stop_run("reset was never released");
      end
      @(posedge clk);
      cycles++;
    end

    // idle after reset, nothing on the bus
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      check_value("reset_idle busy", 32'h0, 32'(busy));
      check_value("reset_idle read_q", 32'h0, 32'(mem_read_q));
      check_value("reset_idle write_q", 32'h0, 32'(mem_write_q));
    end
    fill_memory();

    // straight-line register ops ending in halt
    init_context(base_a, prog_a);
    load_random_program(prog_a, 12);
    end_load();
    run_and_check("straight_line", base_a);
    check_value("straight_line ip", {16'h0000, prog_a + 16'd12},
                mem[word_index(int'(base_a) + int'(reg_ip))]);

    // ldi, top bit of one immediate set to catch sign extension
    init_context(base_a, prog_b);
    for (int k = 0; k < 8; k++) begin
      ldi_imm[k] = (k == 0) ? 16'hffff : 16'($urandom);
      put_word(int'(prog_b) + k, imm_cmd(op_ldi, 4'(k), ldi_imm[k]));
    end
    put_word(int'(prog_b) + 8, reg_cmd(op_halt, 4'd0, 4'd0, 4'd0));
    end_load();
    run_and_check("ldi", base_a);
    for (int k = 0; k < 8; k++) begin
      check_value($sformatf("ldi value r%0d", k), {16'h0000, ldi_imm[k]},
                  mem[word_index(int'(base_a) + k)]);
    end

    // countdown: r1 counts down, r3 counts passes
    init_context(base_a, prog_a);
    count = 5 + int'($urandom % 6);
    put_word(int'(base_a) + 1, 32'(count));
    put_word(int'(base_a) + 2, 32'd1);
    put_word(int'(base_a) + 3, 32'd0);
    put_word(int'(base_a) + 4, 32'd1);
    put_word(int'(prog_a), reg_cmd(op_sub, 4'd1, 4'd1, 4'd2));
    put_word(int'(prog_a) + 1, reg_cmd(op_add, 4'd3, 4'd3, 4'd4));
    put_word(int'(prog_a) + 2, imm_cmd(op_jnz, 4'd1, prog_a));
    put_word(int'(prog_a) + 3, reg_cmd(op_halt, 4'd0, 4'd0, 4'd0));
    end_load();
    run_and_check("countdown", base_a);
    check_value("countdown r1", 32'h0, mem[word_index(int'(base_a) + 1)]);
    check_value("countdown passes", 32'(count), mem[word_index(int'(base_a) + 3)]);
    check_value("countdown ip", {16'h0000, prog_a + 16'd3},
                mem[word_index(int'(base_a) + int'(reg_ip))]);

    // second context right after the first, A must stay as it was
    init_context(base_b, prog_b);
    load_random_program(prog_b, 10);
    end_load();
    void'(run_reference(base_b));
    start_run(base_b);
    wait_busy(1'b1, "two_contexts");
    // start while busy is dropped
    start_run(base_a);
    wait_busy(1'b0, "two_contexts");
    check_context("two_contexts ctx_b", base_b);
    check_context("two_contexts ctx_a", base_a);
    check_value("two_contexts ip", {16'h0000, prog_b + 16'd10},
                mem[word_index(int'(base_b) + int'(reg_ip))]);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: files.f
common/cpu_pkg.sv
common/cpu_ifs.sv
source/cpu_sequencer.sv
fetch/fetch_unit.sv
decode/cmd_decoder.sv
execute/alu_execute.sv
source/result_writer.sv
source/mem_cpu_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_cpu -f files.f -o tb_mem_cpu \
  && ./obj_dir/tb_mem_cpu > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
